// File: Makefile
TOP = gpio_subsys_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall -f tb.f --top-module gpio_subsys_top

clean:
	rm -rf obj_dir sim.log

// File: dv/gpio_subsys_tb.sv
`include "periph_config.svh"

module gpio_subsys_tb
    import periph_pkg::*;
();

    // exp_pins packs the expected gpio_o, gpio_oe_n_o, gpio_pu_o and gpio_pd_o, high byte first.
    typedef struct {
        grant_e      port;
        bit          both;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] adr;
        logic [31:0] wdata;
        logic [31:0] adr_b;
        logic [31:0] wdata_b;
        logic [7:0]  pins;
        bit          chk_rd;
        logic [31:0] exp_rd;
        logic [31:0] exp_pins;
    } row_t;

    logic                  clk;
    logic                  resetn;
    logic                  wba_cyc_i;
    logic                  wba_stb_i;
    logic                  wba_we_i;
    logic [3:0]            wba_sel_i;
    logic [31:0]           wba_adr_i;
    logic [31:0]           wba_dat_i;
    logic [31:0]           wba_dat_o;
    logic                  wba_ack_o;
    logic                  wbb_cyc_i;
    logic                  wbb_stb_i;
    logic                  wbb_we_i;
    logic [3:0]            wbb_sel_i;
    logic [31:0]           wbb_adr_i;
    logic [31:0]           wbb_dat_i;
    logic [31:0]           wbb_dat_o;
    logic                  wbb_ack_o;
    logic [`GPIO_PINS-1:0] gpio_in_i;
    logic [`GPIO_PINS-1:0] gpio_o;
    logic [`GPIO_PINS-1:0] gpio_oe_n_o;
    logic [`GPIO_PINS-1:0] gpio_pu_o;
    logic [`GPIO_PINS-1:0] gpio_pd_o;

    row_t        rows[$];
    logic [31:0] rnd[4];
    int          fails = 0;
    int          rows_bad = 0;
    int          cycles = 0;
    int          cycle_limit = 0;

    gpio_subsys_top UUT (
        .clk_i    (clk),
        .resetn_i (resetn),
        .*
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] reg_addr(input logic [7:0] ofs);
        return {`PERIPH_BASE_PAGE, ofs};
    endfunction

    task automatic add_row(input grant_e port, input logic we, input logic [3:0] sel,
                           input logic [31:0] adr, input logic [31:0] wdata,
                           input logic [7:0] pins, input bit chk_rd,
                           input logic [31:0] exp_rd, input logic [31:0] exp_pins);
        row_t r;
        r = '{port, 1'b0, we, sel, adr, wdata, 32'h0, 32'h0, pins, chk_rd, exp_rd, exp_pins};
        rows.push_back(r);
    endtask

    // both ports write in the same cycle, A to adr_a and B to adr_b.
    task automatic add_pair(input logic [31:0] adr_a, input logic [31:0] wdata_a,
                            input logic [31:0] adr_b, input logic [31:0] wdata_b,
                            input logic [31:0] exp_pins);
        row_t r;
        r = '{GRANT_A, 1'b1, 1'b1, 4'hF, adr_a, wdata_a, adr_b, wdata_b, 8'h00, 1'b0,
              32'h0, exp_pins};
        rows.push_back(r);
    endtask

    task automatic drive_port(input grant_e port, input logic we, input logic [3:0] sel,
                              input logic [31:0] adr, input logic [31:0] wdata);
        if (port == GRANT_A) begin
            wba_cyc_i <= 1'b1;
            wba_stb_i <= 1'b1;
            wba_we_i  <= we;
            wba_sel_i <= sel;
            wba_adr_i <= adr;
            wba_dat_i <= wdata;
        end else begin
            wbb_cyc_i <= 1'b1;
            wbb_stb_i <= 1'b1;
            wbb_we_i  <= we;
            wbb_sel_i <= sel;
            wbb_adr_i <= adr;
            wbb_dat_i <= wdata;
        end
    endtask

    task automatic release_port(input grant_e port);
        if (port == GRANT_A) begin
            wba_cyc_i <= 1'b0;
            wba_stb_i <= 1'b0;
            wba_we_i  <= 1'b0;
        end else begin
            wbb_cyc_i <= 1'b0;
            wbb_stb_i <= 1'b0;
            wbb_we_i  <= 1'b0;
        end
    endtask

    task automatic check_value(input int idx, input string name,
                               input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH row %0d %s: got 0x%h, expected 0x%h", idx, name, got, exp);
            fails++;
        end
    endtask

    task automatic run_row(input int idx);
        row_t        r;
        bit          done_a;
        bit          done_b;
        bit          ack_a;
        bit          ack_b;
        logic [31:0] rd;
        int          fails_before;
        r = rows[idx];
        fails_before = fails;
        rd = 32'h0;
        done_a = !(r.both || r.port == GRANT_A);
        done_b = !(r.both || r.port == GRANT_B);
        @(posedge clk);
        gpio_in_i <= r.pins;
        // give the two-flop synchronizer time before the bank answers.
        repeat (2) @(posedge clk);
        if (r.both) begin
            drive_port(GRANT_A, r.we, r.sel, r.adr, r.wdata);
            drive_port(GRANT_B, r.we, r.sel, r.adr_b, r.wdata_b);
        end else begin
            drive_port(r.port, r.we, r.sel, r.adr, r.wdata);
        end
        while (!(done_a && done_b)) begin
            @(negedge clk);
            ack_a = !done_a && wba_ack_o;
            ack_b = !done_b && wbb_ack_o;
            if (ack_a) rd = wba_dat_o;
            if (ack_b) rd = wbb_dat_o;
            @(posedge clk);
            if (ack_a) begin
                release_port(GRANT_A);
                done_a = 1'b1;
            end
            if (ack_b) begin
                release_port(GRANT_B);
                done_b = 1'b1;
            end
        end
        @(negedge clk);
        if (r.chk_rd) check_value(idx, "wb_dat_o", rd, r.exp_rd);
        check_value(idx, "gpio_o", {24'h0, gpio_o}, {24'h0, r.exp_pins[31:24]});
        check_value(idx, "gpio_oe_n_o", {24'h0, gpio_oe_n_o}, {24'h0, r.exp_pins[23:16]});
        check_value(idx, "gpio_pu_o", {24'h0, gpio_pu_o}, {24'h0, r.exp_pins[15:8]});
        check_value(idx, "gpio_pd_o", {24'h0, gpio_pd_o}, {24'h0, r.exp_pins[7:0]});
        if (fails != fails_before) rows_bad++;
        $display("row %0d: %s", idx, (fails == fails_before) ? "ok" : "mismatch");
    endtask

    initial begin
        rnd[0] = $urandom(40);
        for (int i = 0; i < 4; i++) begin
            rnd[i] = $urandom();
        end

        // reset values, then writes through both ports.
        add_row(GRANT_A, 1'b0, 4'hF, reg_addr(`GPIO_ENA_OFS), 32'h0, 8'h00,
                1'b1, 32'h0000_00FF, 32'h00_FF_00_00);
        add_row(GRANT_A, 1'b1, 4'h1, reg_addr(`GPIO_DATA_OFS), 32'h1234_56A5, 8'h00,
                1'b0, 32'h0, 32'hA5_FF_00_00);
        add_row(GRANT_B, 1'b1, 4'hF, reg_addr(`GPIO_ENA_OFS), 32'h0000_000F, 8'h00,
                1'b0, 32'h0, 32'hA5_0F_00_00);
        add_row(GRANT_A, 1'b1, 4'h1, reg_addr(`GPIO_PU_OFS), 32'h0000_0033, 8'h00,
                1'b0, 32'h0, 32'hA5_0F_33_00);
        add_row(GRANT_B, 1'b1, 4'h1, reg_addr(`GPIO_PD_OFS), 32'hFFFF_FFC0, 8'h00,
                1'b0, 32'h0, 32'hA5_0F_33_C0);
        // readback and input sampling.
        add_row(GRANT_B, 1'b0, 4'hF, reg_addr(`GPIO_DATA_OFS), 32'h0, 8'h5A,
                1'b1, 32'h0000_A55A, 32'hA5_0F_33_C0);
        add_row(GRANT_A, 1'b0, 4'hF, reg_addr(`GPIO_ENA_OFS), 32'h0, 8'h5A,
                1'b1, 32'h0000_000F, 32'hA5_0F_33_C0);
        add_row(GRANT_B, 1'b0, 4'hF, reg_addr(`GPIO_PU_OFS), 32'h0, 8'h5A,
                1'b1, 32'h0000_0033, 32'hA5_0F_33_C0);
        add_row(GRANT_A, 1'b0, 4'hF, reg_addr(`GPIO_PD_OFS), 32'h0, 8'h5A,
                1'b1, 32'h0000_00C0, 32'hA5_0F_33_C0);
        // write gating and the unmapped space.
        add_row(GRANT_A, 1'b1, 4'hE, reg_addr(`GPIO_DATA_OFS), 32'h0000_00FF, 8'h81,
                1'b0, 32'h0, 32'hA5_0F_33_C0);
        add_row(GRANT_A, 1'b0, 4'hF, reg_addr(`GPIO_DATA_OFS), 32'h0, 8'h81,
                1'b1, 32'h0000_A581, 32'hA5_0F_33_C0);
        add_row(GRANT_B, 1'b1, 4'hF, reg_addr(8'h10), 32'hFFFF_FFFF, 8'h81,
                1'b0, 32'h0, 32'hA5_0F_33_C0);
        add_row(GRANT_A, 1'b0, 4'hF, reg_addr(8'h10), 32'h0, 8'h81,
                1'b1, 32'h0, 32'hA5_0F_33_C0);
        add_row(GRANT_A, 1'b1, 4'hF, 32'h2200_0000, 32'h0000_00FF, 8'h81,
                1'b0, 32'h0, 32'hA5_0F_33_C0);
        add_row(GRANT_B, 1'b0, 4'hF, 32'h2200_0000, 32'h0, 8'h81,
                1'b1, 32'h0, 32'hA5_0F_33_C0);
        // contention between the two ports.
        add_pair(reg_addr(`GPIO_PU_OFS), rnd[0], reg_addr(`GPIO_PD_OFS), rnd[1],
                 {8'hA5, 8'h0F, rnd[0][7:0], rnd[1][7:0]});
        add_row(GRANT_B, 1'b0, 4'hF, reg_addr(`GPIO_PU_OFS), 32'h0, 8'h00,
                1'b1, {24'h0, rnd[0][7:0]}, {8'hA5, 8'h0F, rnd[0][7:0], rnd[1][7:0]});
        add_row(GRANT_A, 1'b0, 4'hF, reg_addr(`GPIO_PD_OFS), 32'h0, 8'h00,
                1'b1, {24'h0, rnd[1][7:0]}, {8'hA5, 8'h0F, rnd[0][7:0], rnd[1][7:0]});
        add_pair(reg_addr(`GPIO_PU_OFS), rnd[2], reg_addr(`GPIO_PD_OFS), rnd[3],
                 {8'hA5, 8'h0F, rnd[2][7:0], rnd[3][7:0]});

        cycle_limit = rows.size() * 20 + 5;

        resetn    = 1'b0;
        wba_cyc_i = 1'b0;
        wba_stb_i = 1'b0;
        wba_we_i  = 1'b0;
        wba_sel_i = 4'h0;
        wba_adr_i = 32'h0;
        wba_dat_i = 32'h0;
        wbb_cyc_i = 1'b0;
        wbb_stb_i = 1'b0;
        wbb_we_i  = 1'b0;
        wbb_sel_i = 4'h0;
        wbb_adr_i = 32'h0;
        wbb_dat_i = 32'h0;
        gpio_in_i = '0;
        repeat (5) @(posedge clk);
        resetn <= 1'b1;

        for (int i = 0; i < rows.size(); i++) begin
            run_row(i);
        end

        $display("rows run: %0d, rows with errors: %0d, checks failed: %0d",
                 rows.size(), rows_bad, fails);
        if (fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+verilog
verilog/periph_pkg.sv
verilog/iomem_if.sv
verilog/wb_iomem_bridge.sv
verilog/iomem_arbiter.sv
verilog/gpio_bank.sv
verilog/gpio_subsys_top.sv
dv/gpio_subsys_tb.sv

// File: verilog/gpio_bank.sv
`include "periph_config.svh"

module gpio_bank (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [`GPIO_PINS-1:0] gpio_in_i,
    iomem_if.slave                bus,
    output logic [`GPIO_PINS-1:0] gpio_o,
    output logic [`GPIO_PINS-1:0] gpio_oe_n_o,
    output logic [`GPIO_PINS-1:0] gpio_pu_o,
    output logic [`GPIO_PINS-1:0] gpio_pd_o
);

    logic [`GPIO_PINS-1:0] in_meta_q;
    logic [`GPIO_PINS-1:0] in_sync_q;
    logic                  ready_q;
    logic [31:0]           rdata_q;
    logic [31:0]           rdata_next;
    logic                  page_hit;
    logic                  sel_data;
    logic                  sel_ena;
    logic                  sel_pu;
    logic                  sel_pd;
    logic                  access;

    // two-flop synchronizer on the pad inputs.
    always_ff @(posedge clk) begin
        in_meta_q <= gpio_in_i;
        in_sync_q <= in_meta_q;
    end

    assign page_hit = (bus.addr.f.page == `PERIPH_BASE_PAGE);
    assign sel_data = page_hit && (bus.addr.f.offset == `GPIO_DATA_OFS);
    assign sel_ena  = page_hit && (bus.addr.f.offset == `GPIO_ENA_OFS);
    assign sel_pu   = page_hit && (bus.addr.f.offset == `GPIO_PU_OFS);
    assign sel_pd   = page_hit && (bus.addr.f.offset == `GPIO_PD_OFS);

    // every request is answered, mapped or not.
    assign access = bus.valid && !ready_q;

    always_comb begin
        rdata_next = '0;
        if (sel_data) begin
            rdata_next[`GPIO_PINS-1:0]   = in_sync_q;
            rdata_next[8 +: `GPIO_PINS]  = gpio_o;
        end else if (sel_ena) begin
            rdata_next[`GPIO_PINS-1:0] = gpio_oe_n_o;
        end else if (sel_pu) begin
            rdata_next[`GPIO_PINS-1:0] = gpio_pu_o;
        end else if (sel_pd) begin
            rdata_next[`GPIO_PINS-1:0] = gpio_pd_o;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ready_q     <= 1'b0;
            gpio_o      <= '0;
            gpio_oe_n_o <= '1;
            gpio_pu_o   <= '0;
            gpio_pd_o   <= '0;
        end else begin
            ready_q <= access;
            if (access && bus.wstrb) begin
                if (sel_data) begin
                    gpio_o <= bus.wdata[`GPIO_PINS-1:0];
                end
                if (sel_ena) begin
                    gpio_oe_n_o <= bus.wdata[`GPIO_PINS-1:0];
                end
                if (sel_pu) begin
                    gpio_pu_o <= bus.wdata[`GPIO_PINS-1:0];
                end
                if (sel_pd) begin
                    gpio_pd_o <= bus.wdata[`GPIO_PINS-1:0];
                end
            end
        end
    end

    // read data is captured with the access and presented with ready.
    always_ff @(posedge clk) begin
        if (access) begin
            rdata_q <= rdata_next;
        end
    end

    assign bus.ready = ready_q;
    assign bus.rdata = rdata_q;

    // the request must still be held when its single ready cycle arrives.
    a_ready_pulse: assert property (
        @(posedge clk) disable iff (!resetn)
        bus.ready |-> (bus.valid && !$past(bus.ready))
    );

endmodule

// File: verilog/gpio_subsys_top.sv
`include "periph_config.svh"

module gpio_subsys_top (
    input  logic                  clk_i,
    input  logic                  resetn_i,

    input  logic                  wba_cyc_i,
    input  logic                  wba_stb_i,
    input  logic                  wba_we_i,
    input  logic [3:0]            wba_sel_i,
    input  logic [31:0]           wba_adr_i,
    input  logic [31:0]           wba_dat_i,
    output logic [31:0]           wba_dat_o,
    output logic                  wba_ack_o,

    input  logic                  wbb_cyc_i,
    input  logic                  wbb_stb_i,
    input  logic                  wbb_we_i,
    input  logic [3:0]            wbb_sel_i,
    input  logic [31:0]           wbb_adr_i,
    input  logic [31:0]           wbb_dat_i,
    output logic [31:0]           wbb_dat_o,
    output logic                  wbb_ack_o,

    input  logic [`GPIO_PINS-1:0] gpio_in_i,
    output logic [`GPIO_PINS-1:0] gpio_o,
    output logic [`GPIO_PINS-1:0] gpio_oe_n_o,
    output logic [`GPIO_PINS-1:0] gpio_pu_o,
    output logic [`GPIO_PINS-1:0] gpio_pd_o
);

    iomem_if bus_a ();
    iomem_if bus_b ();
    iomem_if bus_gpio ();

    wb_iomem_bridge u_bridge_a (
        .clk      (clk_i),
        .resetn   (resetn_i),
        .wb_cyc_i (wba_cyc_i),
        .wb_stb_i (wba_stb_i),
        .wb_we_i  (wba_we_i),
        .wb_sel_i (wba_sel_i),
        .wb_adr_i (wba_adr_i),
        .wb_dat_i (wba_dat_i),
        .wb_dat_o (wba_dat_o),
        .wb_ack_o (wba_ack_o),
        .bus      (bus_a.master)
    );

    wb_iomem_bridge u_bridge_b (
        .clk      (clk_i),
        .resetn   (resetn_i),
        .wb_cyc_i (wbb_cyc_i),
        .wb_stb_i (wbb_stb_i),
        .wb_we_i  (wbb_we_i),
        .wb_sel_i (wbb_sel_i),
        .wb_adr_i (wbb_adr_i),
        .wb_dat_i (wbb_dat_i),
        .wb_dat_o (wbb_dat_o),
        .wb_ack_o (wbb_ack_o),
        .bus      (bus_b.master)
    );

    iomem_arbiter u_arbiter (
        .clk    (clk_i),
        .resetn (resetn_i),
        .m_a    (bus_a.slave),
        .m_b    (bus_b.slave),
        .s      (bus_gpio.master)
    );

    gpio_bank u_gpio_bank (
        .clk         (clk_i),
        .resetn      (resetn_i),
        .gpio_in_i   (gpio_in_i),
        .bus         (bus_gpio.slave),
        .gpio_o      (gpio_o),
        .gpio_oe_n_o (gpio_oe_n_o),
        .gpio_pu_o   (gpio_pu_o),
        .gpio_pd_o   (gpio_pd_o)
    );

endmodule

// File: verilog/iomem_arbiter.sv
module iomem_arbiter
    import periph_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    iomem_if.slave  m_a,
    iomem_if.slave  m_b,
    iomem_if.master s
);

    grant_e grant_q;
    grant_e last_q;
    logic   busy_q;
    grant_e pick;
    grant_e sel;

    // when both ports request, the one that did not win last goes first.
    always_comb begin
        if (m_a.valid && m_b.valid) begin
            pick = (last_q == GRANT_A) ? GRANT_B : GRANT_A;
        end else if (m_b.valid) begin
            pick = GRANT_B;
        end else begin
            pick = GRANT_A;
        end
    end

    // a transfer in flight keeps its owner; otherwise the new pick steers the bus.
    assign sel = busy_q ? grant_q : pick;

    assign s.valid    = (sel == GRANT_A) ? m_a.valid : m_b.valid;
    assign s.addr.raw = (sel == GRANT_A) ? m_a.addr.raw : m_b.addr.raw;
    assign s.wstrb    = (sel == GRANT_A) ? m_a.wstrb : m_b.wstrb;
    assign s.wdata    = (sel == GRANT_A) ? m_a.wdata : m_b.wdata;

    // the port that is not selected sees ready low and keeps waiting.
    assign m_a.ready = s.ready && (sel == GRANT_A);
    assign m_b.ready = s.ready && (sel == GRANT_B);
    assign m_a.rdata = s.rdata;
    assign m_b.rdata = s.rdata;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy_q  <= 1'b0;
            grant_q <= GRANT_A;
            last_q  <= GRANT_B;
        end else if (busy_q) begin
            if (s.ready) begin
                busy_q <= 1'b0;
                last_q <= grant_q;
            end
        end else if (s.valid) begin
            busy_q  <= 1'b1;
            grant_q <= sel;
        end
    end

    // ready reaches exactly one port, and only for a transfer already accepted.
    a_single_ready: assert property (
        @(posedge clk) disable iff (!resetn)
        (m_a.ready || m_b.ready) |-> (busy_q && (m_a.ready != m_b.ready))
    );

    a_grant_held: assert property (
        @(posedge clk) disable iff (!resetn)
        (s.valid && !s.ready) |=> (s.valid && $stable(sel))
    );

endmodule

// File: verilog/iomem_if.sv
interface iomem_if
    import periph_pkg::*;
();

    logic        valid;
    logic        ready;
    iomem_addr_u addr;
    logic        wstrb;
    logic [31:0] wdata;
    logic [31:0] rdata;

    // the master holds addr, wstrb and wdata while valid waits for ready.
    modport master (
        output valid,
        output addr,
        output wstrb,
        output wdata,
        input  ready,
        input  rdata
    );

    // the slave answers with a one-cycle ready pulse and rdata alongside it.
    modport slave (
        input  valid,
        input  addr,
        input  wstrb,
        input  wdata,
        output ready,
        output rdata
    );

endinterface

// File: verilog/periph_config.svh
`ifndef PERIPH_CONFIG_SVH
`define PERIPH_CONFIG_SVH

// upper 24 address bits of the page that holds the GPIO bank.
`define PERIPH_BASE_PAGE 24'h210000

// register offsets within the page.
`define GPIO_DATA_OFS 8'h00
`define GPIO_ENA_OFS  8'h04
`define GPIO_PU_OFS   8'h08
`define GPIO_PD_OFS   8'h0C

// number of pins in the bank. The DATA readback layout assumes it fits in a byte.
`define GPIO_PINS 8

`endif

// File: verilog/periph_pkg.sv
package periph_pkg;

    // an iomem address split into the peripheral page and the register offset.
    typedef struct packed {
        logic [23:0] page;
        logic [7:0]  offset;
    } iomem_addr_s;

    // the same word seen either as plain bits or as page and offset.
    typedef union packed {
        logic [31:0] raw;
        iomem_addr_s f;
    } iomem_addr_u;

    // which host port owns the shared bus.
    typedef enum logic {
        GRANT_A,
        GRANT_B
    } grant_e;

endpackage

// File: verilog/wb_iomem_bridge.sv
module wb_iomem_bridge (
    input  logic        clk,
    input  logic        resetn,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [3:0]  wb_sel_i,
    input  logic [31:0] wb_adr_i,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o,
    iomem_if.master     bus
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_DONE
    } state_e;

    state_e      state_q;
    logic [31:0] addr_q;
    logic [31:0] wdata_q;
    logic        wstrb_q;
    logic [31:0] rdata_q;
    logic        wb_req;

    assign wb_req = wb_cyc_i && wb_stb_i;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (wb_req) begin
                        state_q <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    if (bus.ready) begin
                        state_q <= ST_DONE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // only lane 0 carries pin data, so sel bit 0 alone qualifies a write.
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && wb_req) begin
            addr_q  <= wb_adr_i;
            wdata_q <= wb_dat_i;
            wstrb_q <= wb_we_i && wb_sel_i[0];
        end
        if (state_q == ST_BUSY && bus.ready) begin
            rdata_q <= bus.rdata;
        end
    end

    assign bus.valid    = (state_q == ST_BUSY);
    assign bus.addr.raw = addr_q;
    assign bus.wstrb    = wstrb_q;
    assign bus.wdata    = wdata_q;

    // the done state lasts one cycle and is the Wishbone ack.
    assign wb_ack_o = (state_q == ST_DONE);
    assign wb_dat_o = rdata_q;

    a_req_stable: assert property (
        @(posedge clk) disable iff (!resetn)
        (bus.valid && !bus.ready) |=>
            ($stable(bus.addr.raw) && $stable(bus.wdata) && $stable(bus.wstrb))
    );

endmodule
